/* design/bitop_axil_decode.sv */
module bitop_axil_decode import bitop_pkg::*; #(
    parameter int ADDR_W = 5
) (
    input  logic              clk_i,
    input  logic              rst_i,

    // Write address and data
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  word_t             wdata_i,
    input  logic              wvalid_i,
    output logic              wready_o,

    // Write response
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,

    // Read address and data
    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output word_t             rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,

    // Execute and result side
    input  word_t             result_i,
    input  word_t             status_i,
    input  logic              busy_i,
    output word_t             rs1_o,
    output word_t             rs2_o,
    output op_t               op_o,
    output logic              start_o,
    output logic              op_err_o
);

    axil_state_t wr_state;
    axil_state_t rd_state;

    logic        wr_fire;
    logic        rd_fire;
    logic [4:0]  wr_off;
    logic [4:0]  rd_off;
    op_t         wr_op;
    logic        wr_op_legal;

    word_t       rs1_q;
    word_t       rs2_q;
    op_t         op_q;
    logic        start_q;
    logic        op_err_q;
    word_t       rdata_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Address and data are only taken together
    assign wr_fire     = (wr_state == IDLE) && awvalid_i && wvalid_i;
    assign awready_o   = wr_fire;
    assign wready_o    = wr_fire;
    assign bvalid_o    = (wr_state == RESP);
    assign bresp_o     = 2'b00;

    assign wr_off      = awaddr_i[4:0];
    assign wr_op       = wdata_i[2:0];
    assign wr_op_legal = (wr_op <= OP_CNTP);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state <= IDLE;
            op_q     <= OP_HMDST;
            start_q  <= 1'b0;
            op_err_q <= 1'b0;
        end else begin
            start_q  <= 1'b0;
            op_err_q <= 1'b0;
            case (wr_state)
                IDLE: begin
                    if (wr_fire) begin
                        wr_state <= RESP;
                        // A CTRL write while busy is acknowledged and dropped
                        if (wr_off == REG_CTRL && !busy_i) begin
                            if (wr_op_legal) begin
                                op_q    <= wr_op;
                                start_q <= 1'b1;
                            end else begin
                                op_err_q <= 1'b1;
                            end
                        end
                    end
                end
                RESP: begin
                    if (bready_i) begin
                        wr_state <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            if (wr_off == REG_RS1) begin
                rs1_q <= wdata_i;
            end
            if (wr_off == REG_RS2) begin
                rs2_q <= wdata_i;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_fire   = (rd_state == IDLE) && arvalid_i;
    assign arready_o = (rd_state == IDLE);
    assign rvalid_o  = (rd_state == RESP);
    assign rresp_o   = 2'b00;
    assign rd_off    = araddr_i[4:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state <= IDLE;
        end else begin
            case (rd_state)
                IDLE:    if (rd_fire) rd_state <= RESP;
                RESP:    if (rready_i) rd_state <= IDLE;
                default: rd_state <= IDLE;
            endcase
        end
    end

    // Data is captured at the handshake and held while rvalid waits
    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            case (rd_off)
                REG_RS1:    rdata_q <= rs1_q;
                REG_RS2:    rdata_q <= rs2_q;
                REG_CTRL:   rdata_q <= {29'd0, op_q};
                REG_RESULT: rdata_q <= result_i;
                REG_STATUS: rdata_q <= status_i;
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o  = rdata_q;
    assign rs1_o    = rs1_q;
    assign rs2_o    = rs2_q;
    assign op_o     = op_q;
    assign start_o  = start_q;
    assign op_err_o = op_err_q;

endmodule

/* design/bitop_execute.sv */
module bitop_execute import bitop_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  start_i,
    input  word_t rs1_i,
    input  word_t rs2_i,
    input  op_t   op_i,
    output word_t result_o,
    output logic  ready_o
);

    word_t       pc_in;
    word_t       pc_s1;
    word_t       pc_s2;
    word_t       pc_s3;
    logic [5:0]  pc_cnt;

    word_t       rev;
    word_t       ctz_x;
    logic [5:0]  ctz_cnt;
    word_t       sladd;
    word_t       pkg_word;
    word_t       sel;

    word_t       result_q;
    logic        ready_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Population count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Hamming distance is the popcount of the XOR, so both share this network
    assign pc_in = (op_i == OP_HMDST) ? (rs1_i ^ rs2_i) : rs1_i;

    // Two-bit fields, then nibbles, then bytes
    assign pc_s1 = pc_in - ((pc_in >> 1) & 32'h5555_5555);
    assign pc_s2 = (pc_s1 & 32'h3333_3333) + ((pc_s1 >> 2) & 32'h3333_3333);
    assign pc_s3 = (pc_s2 + (pc_s2 >> 4)) & 32'h0F0F_0F0F;

    assign pc_cnt = 6'(pc_s3[7:0]) + 6'(pc_s3[15:8])
                  + 6'(pc_s3[23:16]) + 6'(pc_s3[31:24]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Other operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            rev[31-i] = rs1_i[i];
        end
    end

    // The last step of the binary search only fires for a zero word
    always_comb begin
        ctz_x   = rs1_i;
        ctz_cnt = '0;
        if (ctz_x[15:0] == 16'd0) begin
            ctz_cnt = ctz_cnt + 6'd16;
            ctz_x   = ctz_x >> 16;
        end
        if (ctz_x[7:0] == 8'd0) begin
            ctz_cnt = ctz_cnt + 6'd8;
            ctz_x   = ctz_x >> 8;
        end
        if (ctz_x[3:0] == 4'd0) begin
            ctz_cnt = ctz_cnt + 6'd4;
            ctz_x   = ctz_x >> 4;
        end
        if (ctz_x[1:0] == 2'd0) begin
            ctz_cnt = ctz_cnt + 6'd2;
            ctz_x   = ctz_x >> 2;
        end
        if (ctz_x[0] == 1'b0) begin
            ctz_cnt = ctz_cnt + 6'd1;
            ctz_x   = ctz_x >> 1;
        end
        if (ctz_x[0] == 1'b0) begin
            ctz_cnt = ctz_cnt + 6'd1;
        end
    end

    assign sladd    = (rs1_i << 1) + rs2_i;
    assign pkg_word = {rs2_i[15:0], rs1_i[15:0]};

    always_comb begin
        case (op_i)
            OP_HMDST: sel = {26'd0, pc_cnt};
            OP_PKG:   sel = pkg_word;
            OP_RVRS:  sel = rev;
            OP_SLADD: sel = sladd;
            OP_CNTZ:  sel = {26'd0, ctz_cnt};
            OP_CNTP:  sel = {26'd0, pc_cnt};
            default:  sel = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= start_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            result_q <= sel;
        end
    end

    assign result_o = result_q;
    assign ready_o  = ready_q;

endmodule

/* design/bitop_pkg.sv */
package bitop_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] word_t;
    typedef logic [2:0]  op_t;

    // Codes 110 and 111 are illegal
    localparam op_t OP_HMDST = 3'd0;
    localparam op_t OP_PKG   = 3'd1;
    localparam op_t OP_RVRS  = 3'd2;
    localparam op_t OP_SLADD = 3'd3;
    localparam op_t OP_CNTZ  = 3'd4;
    localparam op_t OP_CNTP  = 3'd5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Only the low five bits of a byte address are decoded
    localparam logic [4:0] REG_RS1    = 5'h00;
    localparam logic [4:0] REG_RS2    = 5'h04;
    localparam logic [4:0] REG_CTRL   = 5'h08;
    localparam logic [4:0] REG_RESULT = 5'h0C;
    localparam logic [4:0] REG_STATUS = 5'h10;

    // Bit positions in the status word
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_ERR  = 2;

    // Shared by the write and read channel FSMs
    typedef enum logic {
        IDLE,
        RESP
    } axil_state_t;

endpackage

/* design/bitop_result.sv */
module bitop_result import bitop_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  start_i,
    input  logic  op_err_i,
    input  logic  ready_i,
    input  word_t result_i,
    output word_t result_o,
    output word_t status_o,
    output logic  busy_o
);

    word_t result_q;
    logic  busy_q;
    logic  done_q;
    logic  err_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q <= '0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            if (start_i) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
                err_q  <= 1'b0;
            end
            if (ready_i) begin
                result_q <= result_i;
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
            end
            // The stored result survives an illegal opcode
            if (op_err_i) begin
                err_q <= 1'b1;
            end
        end
    end

    always_comb begin
        status_o            = '0;
        status_o[STAT_BUSY] = busy_q;
        status_o[STAT_DONE] = done_q;
        status_o[STAT_ERR]  = err_q;
    end

    assign result_o = result_q;
    assign busy_o   = busy_q;

endmodule

/* design/bitop_top.sv */
module bitop_top import bitop_pkg::*; #(
    parameter int ADDR_W = 5
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  word_t             wdata_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output word_t             rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i
);

    word_t rs1;
    word_t rs2;
    op_t   op;
    logic  start;
    logic  op_err;
    word_t exe_result;
    logic  ready;
    word_t result;
    word_t status;
    logic  busy;

    bitop_axil_decode #(
        .ADDR_W (ADDR_W)
    ) u_decode (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .result_i  (result),
        .status_i  (status),
        .busy_i    (busy),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .op_o      (op),
        .start_o   (start),
        .op_err_o  (op_err)
    );

    bitop_execute u_execute (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .op_i     (op),
        .result_o (exe_result),
        .ready_o  (ready)
    );

    bitop_result u_result (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start),
        .op_err_i (op_err),
        .ready_i  (ready),
        .result_i (exe_result),
        .result_o (result),
        .status_o (status),
        .busy_o   (busy)
    );

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module bitop_tb \
    -f src.f \
    -o bitop_sim

./obj_dir/bitop_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/bitop_tb.sv */
module bitop_tb import bitop_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W     = 5;
    localparam int WAIT_LIMIT = 100;
    localparam int POLL_LIMIT = 20;

    localparam word_t DONE_MASK = 32'(1) << STAT_DONE;
    localparam word_t ERR_MASK  = 32'(1) << STAT_ERR;

    // Zero, all ones, single bits and alternating patterns
    localparam word_t PATTERNS [0:6] = '{
        32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000,
        32'h5555_5555, 32'hAAAA_AAAA, 32'h0001_0000
    };

    logic              clk_i;
    logic              rst_i;
    logic [ADDR_W-1:0] awaddr_i;
    logic              awvalid_i;
    logic              awready_o;
    word_t             wdata_i;
    logic              wvalid_i;
    logic              wready_o;
    logic [1:0]        bresp_o;
    logic              bvalid_o;
    logic              bready_i;
    logic [ADDR_W-1:0] araddr_i;
    logic              arvalid_i;
    logic              arready_o;
    word_t             rdata_o;
    logic [1:0]        rresp_o;
    logic              rvalid_o;
    logic              rready_i;

    bitop_top #(
        .ADDR_W (ADDR_W)
    ) uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and failure
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check(input word_t actual, input word_t expected, input string msg);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            abort_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite bus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Outputs are sampled right after the edge, so they still hold their pre-edge values
    task automatic axil_write(input logic [4:0] addr, input word_t data, input int hold);
        int n;
        @(posedge clk_i);
        awaddr_i  <= addr;
        wdata_i   <= data;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT) timed_out("the write address and data handshake");
        end while (!(awready_o && wready_o));
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT) timed_out("the write response");
        end while (!bvalid_o);
        repeat (hold) begin
            @(posedge clk_i);
            check(32'(bvalid_o), 32'd1, "bvalid dropped before bready");
        end
        bready_i <= 1'b1;
        @(posedge clk_i);
        check(32'(bvalid_o), 32'd1, "bvalid low at the response handshake");
        check(32'(bresp_o), 32'd0, "write response code");
        bready_i <= 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output word_t data, input int hold);
        int    n;
        word_t first;
        @(posedge clk_i);
        araddr_i  <= addr;
        arvalid_i <= 1'b1;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT) timed_out("the read address handshake");
        end while (!arready_o);
        arvalid_i <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT) timed_out("the read data");
        end while (!rvalid_o);
        first = rdata_o;
        repeat (hold) begin
            @(posedge clk_i);
            check(32'(rvalid_o), 32'd1, "rvalid dropped before rready");
            check(32'(arready_o), 32'd0, "new read accepted while rvalid waits");
            check(rdata_o, first, "rdata changed while rvalid waits");
        end
        rready_i <= 1'b1;
        @(posedge clk_i);
        check(32'(rvalid_o), 32'd1, "rvalid low at the data handshake");
        check(32'(rresp_o), 32'd0, "read response code");
        check(rdata_o, first, "rdata changed at the data handshake");
        data = rdata_o;
        rready_i <= 1'b0;
    endtask

    task automatic wait_status(input word_t mask, output word_t status);
        int    n;
        word_t s;
        n = 0;
        do begin
            axil_read(REG_STATUS, s, 0);
            n++;
            if (n > POLL_LIMIT) timed_out("a status flag");
        end while ((s & mask) == 32'd0);
        status = s;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic word_t ones_count(input word_t x);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            if (x[i]) n++;
        end
        return word_t'(n);
    endfunction

    // Scans from the top so the lowest set bit is written last
    function automatic word_t trailing_zeros(input word_t x);
        int n;
        n = 32;
        for (int i = 31; i >= 0; i--) begin
            if (x[i]) n = i;
        end
        return word_t'(n);
    endfunction

    function automatic word_t bit_reverse(input word_t x);
        word_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = x[31-i];
        end
        return r;
    endfunction

    function automatic word_t expected_result(input op_t op, input word_t a, input word_t b);
        case (op)
            OP_HMDST: return ones_count(a ^ b);
            OP_PKG:   return {b[15:0], a[15:0]};
            OP_RVRS:  return bit_reverse(a);
            OP_SLADD: return a + a + b;
            OP_CNTZ:  return trailing_zeros(a);
            OP_CNTP:  return ones_count(a);
            default:  return '0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_op(input op_t op, input word_t a, input word_t b,
                          input word_t expected, input string name);
        word_t status;
        word_t result;
        axil_write(REG_RS1, a, 0);
        axil_write(REG_RS2, b, 0);
        axil_write(REG_CTRL, 32'(op), 0);
        wait_status(DONE_MASK, status);
        check(status, DONE_MASK, {name, " status"});
        axil_read(REG_RESULT, result, 0);
        check(result, expected, name);
    endtask

    task automatic reset_state_test();
        word_t d;
        axil_read(REG_STATUS, d, 0);
        check(d, 32'd0, "status after reset");
        axil_read(REG_RESULT, d, 0);
        check(d, 32'd0, "result after reset");
    endtask

    task automatic corner_test();
        word_t a;
        word_t b;
        run_op(OP_CNTZ, 32'h0000_0000, 32'h0, 32'd32, "ctz of zero");
        run_op(OP_CNTZ, 32'h8000_0000, 32'h0, 32'd31, "ctz of top bit");
        run_op(OP_SLADD, 32'hFFFF_FFFF, 32'h2, 32'h0, "shift-one-add wrap");
        run_op(OP_CNTP, 32'hFFFF_FFFF, 32'h0, 32'd32, "popcount of all ones");
        run_op(OP_HMDST, 32'h5555_5555, 32'hAAAA_AAAA, 32'd32, "hamming of alternates");
        run_op(OP_RVRS, 32'h0000_0001, 32'h0, 32'h8000_0000, "reverse of bit zero");
        run_op(OP_PKG, 32'h1234_ABCD, 32'h5678_EF01, 32'hEF01_ABCD, "pack halves");
        for (int i = 0; i < 7; i++) begin
            a = PATTERNS[i];
            b = PATTERNS[(i + 3) % 7];
            for (int k = 0; k < 6; k++) begin
                run_op(op_t'(k), a, b, expected_result(op_t'(k), a, b),
                       $sformatf("pattern %0d op %0d", i, k));
            end
        end
    endtask

    task automatic random_test();
        word_t a;
        word_t b;
        op_t   op;
        for (int i = 0; i < 200; i++) begin
            a  = $urandom;
            b  = $urandom;
            op = op_t'($urandom % 6);
            run_op(op, a, b, expected_result(op, a, b), $sformatf("random op %0d", i));
        end
    endtask

    task automatic illegal_test();
        word_t a;
        word_t status;
        word_t d;
        for (int code = 6; code < 8; code++) begin
            a = $urandom;
            run_op(OP_CNTP, a, 32'h0, ones_count(a), "popcount before illegal code");
            axil_write(REG_CTRL, word_t'(code), 0);
            wait_status(ERR_MASK, status);
            check(32'(status[STAT_BUSY]), 32'd0, "busy after illegal code");
            axil_read(REG_RESULT, d, 0);
            check(d, ones_count(a), "result after illegal code");
            // An illegal code is not latched as the last op
            axil_read(REG_CTRL, d, 0);
            check(d, 32'(OP_CNTP), "last op after illegal code");
        end
        // run_op expects a status of done alone, so err must be cleared here
        run_op(OP_RVRS, 32'h0000_00F0, 32'h0, 32'h0F00_0000, "legal op after illegal");
    endtask

    task automatic readback_test();
        word_t a;
        word_t b;
        word_t d;
        a = $urandom;
        b = $urandom;
        axil_write(REG_RS1, a, 0);
        axil_write(REG_RS2, b, 0);
        axil_read(REG_RS1, d, 0);
        check(d, a, "rs1 readback");
        axil_read(REG_RS2, d, 0);
        check(d, b, "rs2 readback");
        for (int off = 5'h14; off <= 5'h1C; off += 4) begin
            axil_read(5'(off), d, 0);
            check(d, 32'd0, $sformatf("unmapped offset %h", off));
        end
    endtask

    task automatic backpressure_test();
        word_t a;
        word_t b;
        word_t d;
        int    wr_hold;
        int    rd_hold;
        for (int i = 0; i < 8; i++) begin
            a       = $urandom;
            b       = $urandom;
            wr_hold = int'($urandom % 8) + 1;
            rd_hold = int'($urandom % 8) + 1;
            axil_write(REG_RS1, a, wr_hold);
            // RS1 is overwritten while the read of its old value waits for rready
            fork
                axil_read(REG_RS1, d, rd_hold);
                axil_write(REG_RS1, b, 0);
            join
            check(d, a, "rs1 under back-pressure");
            axil_read(REG_RS1, d, 0);
            check(d, b, "rs1 after the overlapping write");
        end
    endtask

    initial begin
        rst_i     = 1'b1;
        awaddr_i  = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wvalid_i  = 1'b0;
        bready_i  = 1'b0;
        araddr_i  = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        void'($urandom(60471));
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        reset_state_test();
        corner_test();
        random_test();
        illegal_test();
        readback_test();
        backpressure_test();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* src.f */
design/bitop_pkg.sv
design/bitop_axil_decode.sv
design/bitop_execute.sv
design/bitop_result.sv
design/bitop_top.sv
sim/bitop_tb.sv
